// ==== src/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // --------------------
    // APB port widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // Register offset seen by each slave
    localparam int OFFS_W = 8;

    // Slave number in address bits 15 to 12
    typedef enum logic [3:0] {
        SLV_TEST  = 4'd0,
        SLV_TIMER = 4'd1,
        SLV_IRQ   = 4'd2
    } slave_e;

endpackage

`default_nettype wire

// ==== src/periph_pkg.sv ====
`default_nettype none

package periph_pkg;

    // Timer clock divider
    // Code 3 runs as DIV256
    typedef enum logic [1:0] {
        PRE_DIV1   = 2'd0,
        PRE_DIV16  = 2'd1,
        PRE_DIV256 = 2'd2
    } prescale_e;

    // --------------------
    // Timer register offsets inside the 0x10 block of one timer
    localparam logic [3:0] TMR_LOAD  = 4'h0;
    localparam logic [3:0] TMR_VALUE = 4'h4;
    localparam logic [3:0] TMR_CTRL  = 4'h8;
    localparam logic [3:0] TMR_CLEAR = 4'hC;

    // --------------------
    // Interrupt controller registers
    localparam logic [bus_pkg::OFFS_W-1:0] IRQ_STATUS  = 8'h00;
    localparam logic [bus_pkg::OFFS_W-1:0] IRQ_RAW     = 8'h04;
    localparam logic [bus_pkg::OFFS_W-1:0] IRQ_EN_SET  = 8'h08;
    localparam logic [bus_pkg::OFFS_W-1:0] IRQ_EN_CLR  = 8'h0C;
    localparam logic [bus_pkg::OFFS_W-1:0] FIRQ_STATUS = 8'h20;
    localparam logic [bus_pkg::OFFS_W-1:0] FIRQ_EN_SET = 8'h28;
    localparam logic [bus_pkg::OFFS_W-1:0] FIRQ_EN_CLR = 8'h2C;

    // --------------------
    // Test registers and their reset values
    localparam logic [bus_pkg::OFFS_W-1:0] TST_ID  = 8'h00;
    localparam logic [bus_pkg::OFFS_W-1:0] TST_LED = 8'h04;
    localparam logic [bus_pkg::OFFS_W-1:0] TST_PHY = 8'h08;
    localparam logic [bus_pkg::OFFS_W-1:0] TST_SWI = 8'h0C;

    localparam logic [bus_pkg::DATA_W-1:0] TEST_ID = 32'h0A23_0001;
    localparam logic [3:0] LED_RESET = 4'h0;
    localparam logic PHY_RESET = 1'b0;   // PHY held in reset

    // Interrupt source bits with timer n at SRC_TIMER0 + n
    localparam int SRC_EXT0   = 0;
    localparam int SRC_EXT1   = 1;
    localparam int SRC_SWI    = 2;
    localparam int SRC_SWFI   = 3;
    localparam int SRC_TIMER0 = 4;

endpackage

`default_nettype wire

// ==== src/apb_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_decoder (
    input  wire                          i_clk,
    input  wire                          i_arst_n,
    input  wire                          i_psel,
    input  wire                          i_penable,
    input  wire                          i_pwrite,
    input  wire  [bus_pkg::ADDR_W-1:0]   i_paddr,
    input  wire  [bus_pkg::DATA_W-1:0]   i_pwdata,
    input  wire  [bus_pkg::DATA_W-1:0]   i_test_rdata,
    input  wire  [bus_pkg::DATA_W-1:0]   i_timer_rdata,
    input  wire  [bus_pkg::DATA_W-1:0]   i_irq_rdata,
    output logic [bus_pkg::DATA_W-1:0]   o_prdata,
    output logic                         o_pready,
    output logic                         o_pslverr,
    output logic [bus_pkg::OFFS_W-1:0]   o_offset,
    output logic [bus_pkg::DATA_W-1:0]   o_wdata,
    output logic                         o_test_we,
    output logic                         o_timer_we,
    output logic                         o_irq_we
);

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_SETUP,
        PH_ACCESS
    } phase_e;

    phase_e phase_q;
    phase_e phase_d;
    bus_pkg::slave_e slv;
    logic access_cyc;
    logic valid_acc;
    logic mapped;
    logic wr_ok;
    logic [bus_pkg::DATA_W-1:0] sel_rdata;

    // --------------------
    // Phase of the previous cycle
    always_comb begin
        if (!i_psel) begin
            phase_d = PH_IDLE;
        end else if (!i_penable) begin
            phase_d = PH_SETUP;
        end else if (phase_q == PH_SETUP) begin
            phase_d = PH_ACCESS;
        end else begin
            // Access without setup, or access held past one cycle
            phase_d = PH_IDLE;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            phase_q <= PH_IDLE;
        end else begin
            phase_q <= phase_d;
        end
    end

    assign access_cyc = i_psel & i_penable;
    assign valid_acc  = access_cyc & (phase_q == PH_SETUP);

    // --------------------
    // Slave select from the top address nibble
    assign slv = bus_pkg::slave_e'(i_paddr[bus_pkg::ADDR_W-1 -: 4]);

    always_comb begin
        mapped    = 1'b1;
        sel_rdata = '0;
        case (slv)
            bus_pkg::SLV_TEST:  sel_rdata = i_test_rdata;
            bus_pkg::SLV_TIMER: sel_rdata = i_timer_rdata;
            bus_pkg::SLV_IRQ:   sel_rdata = i_irq_rdata;
            default:            mapped = 1'b0;
        endcase
    end

    assign wr_ok = valid_acc & mapped & i_pwrite;

    assign o_test_we  = wr_ok & (slv == bus_pkg::SLV_TEST);
    assign o_timer_we = wr_ok & (slv == bus_pkg::SLV_TIMER);
    assign o_irq_we   = wr_ok & (slv == bus_pkg::SLV_IRQ);

    assign o_offset = i_paddr[bus_pkg::OFFS_W-1:0];
    assign o_wdata  = i_pwdata;

    // Zero wait states with an error on an unmapped slave or a protocol error
    assign o_pready  = access_cyc;
    assign o_pslverr = access_cyc & ~(valid_acc & mapped);
    assign o_prdata  = (valid_acc & mapped & ~i_pwrite) ? sel_rdata : '0;

endmodule

`default_nettype wire

// ==== src/timer_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module timer_bank #(
    parameter int N_TIMERS = 3
) (
    input  wire                          i_clk,
    input  wire                          i_arst_n,
    input  wire                          i_we,
    input  wire  [bus_pkg::OFFS_W-1:0]   i_offset,
    input  wire  [bus_pkg::DATA_W-1:0]   i_wdata,
    output logic [bus_pkg::DATA_W-1:0]   o_rdata,
    output logic [N_TIMERS-1:0]          o_timer_int
);

    localparam int CNT_W = 16;
    localparam int PRE_W = 8;

    logic [CNT_W-1:0] load_q [N_TIMERS];
    logic [CNT_W-1:0] cnt_q  [N_TIMERS];
    periph_pkg::prescale_e pre_q [N_TIMERS];
    logic [N_TIMERS-1:0] en_q;
    logic [N_TIMERS-1:0] per_q;
    logic [N_TIMERS-1:0] int_q;
    logic [PRE_W-1:0] pre_cnt_q;
    logic [N_TIMERS-1:0] sel;
    logic [N_TIMERS-1:0] tick;
    logic [N_TIMERS-1:0] fire;
    logic [3:0] reg_offs;

    assign reg_offs = i_offset[3:0];

    // --------------------
    // Per timer select, tick and terminal count
    always_comb begin
        for (int i = 0; i < N_TIMERS; i++) begin
            sel[i] = i_we && (i_offset[bus_pkg::OFFS_W-1:4] == 4'(i));
            case (pre_q[i])
                periph_pkg::PRE_DIV1:  tick[i] = 1'b1;
                periph_pkg::PRE_DIV16: tick[i] = &pre_cnt_q[3:0];
                default:               tick[i] = &pre_cnt_q;
            endcase
            fire[i] = en_q[i] && tick[i] && (cnt_q[i] == CNT_W'(1));
        end
    end

    // Reload value of each timer
    always_ff @(posedge i_clk) begin
        for (int i = 0; i < N_TIMERS; i++) begin
            if (sel[i] && reg_offs == periph_pkg::TMR_LOAD) begin
                load_q[i] <= i_wdata[CNT_W-1:0];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pre_cnt_q <= '0;
            en_q      <= '0;
            per_q     <= '0;
            int_q     <= '0;
            for (int i = 0; i < N_TIMERS; i++) begin
                cnt_q[i] <= '0;
                pre_q[i] <= periph_pkg::PRE_DIV1;
            end
        end else begin
            pre_cnt_q <= pre_cnt_q + PRE_W'(1);
            for (int i = 0; i < N_TIMERS; i++) begin
                // A write to the load register wins over counting
                if (sel[i] && reg_offs == periph_pkg::TMR_LOAD) begin
                    cnt_q[i] <= i_wdata[CNT_W-1:0];
                end else if (en_q[i] && tick[i]) begin
                    if (cnt_q[i] != '0) begin
                        cnt_q[i] <= cnt_q[i] - CNT_W'(1);
                    end else if (per_q[i]) begin
                        cnt_q[i] <= load_q[i];
                    end
                end

                if (sel[i] && reg_offs == periph_pkg::TMR_CTRL) begin
                    en_q[i]  <= i_wdata[7];
                    per_q[i] <= i_wdata[6];
                    pre_q[i] <= periph_pkg::prescale_e'(i_wdata[3:2]);
                end

                // A new terminal count is not lost to a clear
                if (fire[i]) begin
                    int_q[i] <= 1'b1;
                end else if (sel[i] && reg_offs == periph_pkg::TMR_CLEAR) begin
                    int_q[i] <= 1'b0;
                end
            end
        end
    end

    // --------------------
    // Read data
    always_comb begin
        o_rdata = '0;
        for (int i = 0; i < N_TIMERS; i++) begin
            if (i_offset[bus_pkg::OFFS_W-1:4] == 4'(i)) begin
                case (reg_offs)
                    periph_pkg::TMR_LOAD:  o_rdata[CNT_W-1:0] = load_q[i];
                    periph_pkg::TMR_VALUE: o_rdata[CNT_W-1:0] = cnt_q[i];
                    periph_pkg::TMR_CTRL:  o_rdata[7:0] = {en_q[i], per_q[i], 2'b00,
                                                           pre_q[i], 2'b00};
                    default: ;
                endcase
            end
        end
    end

    assign o_timer_int = int_q;

endmodule

`default_nettype wire

// ==== src/irq_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module irq_controller #(
    parameter int N_TIMERS = 3
) (
    input  wire                          i_clk,
    input  wire                          i_arst_n,
    input  wire                          i_we,
    input  wire  [bus_pkg::OFFS_W-1:0]   i_offset,
    input  wire  [bus_pkg::DATA_W-1:0]   i_wdata,
    input  wire  [1:0]                   i_ext_int,
    input  wire                          i_swi,
    input  wire                          i_swfi,
    input  wire  [N_TIMERS-1:0]          i_timer_int,
    output logic [bus_pkg::DATA_W-1:0]   o_rdata,
    output logic                         o_irq,
    output logic                         o_firq
);

    localparam int N_SRC = periph_pkg::SRC_TIMER0 + N_TIMERS;

    logic [N_SRC-1:0] raw;
    logic [N_SRC-1:0] irq_en_q;
    logic [N_SRC-1:0] firq_en_q;
    logic [N_SRC-1:0] irq_stat;
    logic [N_SRC-1:0] firq_stat;
    logic [N_SRC-1:0] wbits;

    // --------------------
    // Raw source vector
    always_comb begin
        raw[periph_pkg::SRC_EXT0] = i_ext_int[0];
        raw[periph_pkg::SRC_EXT1] = i_ext_int[1];
        raw[periph_pkg::SRC_SWI]  = i_swi;
        raw[periph_pkg::SRC_SWFI] = i_swfi;
        raw[periph_pkg::SRC_TIMER0 +: N_TIMERS] = i_timer_int;
    end

    assign irq_stat  = raw & irq_en_q;
    assign firq_stat = raw & firq_en_q;
    assign wbits     = i_wdata[N_SRC-1:0];

    // Masks use write-one-to-set and write-one-to-clear
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            irq_en_q  <= '0;
            firq_en_q <= '0;
            o_irq     <= 1'b0;
            o_firq    <= 1'b0;
        end else begin
            if (i_we) begin
                case (i_offset)
                    periph_pkg::IRQ_EN_SET:  irq_en_q  <= irq_en_q | wbits;
                    periph_pkg::IRQ_EN_CLR:  irq_en_q  <= irq_en_q & ~wbits;
                    periph_pkg::FIRQ_EN_SET: firq_en_q <= firq_en_q | wbits;
                    periph_pkg::FIRQ_EN_CLR: firq_en_q <= firq_en_q & ~wbits;
                    default: ;
                endcase
            end
            o_irq  <= |irq_stat;
            o_firq <= |firq_stat;
        end
    end

    // --------------------
    // Read data
    always_comb begin
        o_rdata = '0;
        case (i_offset)
            periph_pkg::IRQ_STATUS:  o_rdata[N_SRC-1:0] = irq_stat;
            periph_pkg::IRQ_RAW:     o_rdata[N_SRC-1:0] = raw;
            periph_pkg::IRQ_EN_SET:  o_rdata[N_SRC-1:0] = irq_en_q;
            periph_pkg::FIRQ_STATUS: o_rdata[N_SRC-1:0] = firq_stat;
            periph_pkg::FIRQ_EN_SET: o_rdata[N_SRC-1:0] = firq_en_q;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/test_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module test_regs (
    input  wire                          i_clk,
    input  wire                          i_arst_n,
    input  wire                          i_we,
    input  wire  [bus_pkg::OFFS_W-1:0]   i_offset,
    input  wire  [bus_pkg::DATA_W-1:0]   i_wdata,
    output logic [bus_pkg::DATA_W-1:0]   o_rdata,
    output logic [3:0]                   o_led,
    output logic                         o_phy_rst_n,
    output logic                         o_swi,
    output logic                         o_swfi
);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_led       <= periph_pkg::LED_RESET;
            o_phy_rst_n <= periph_pkg::PHY_RESET;
            o_swi       <= 1'b0;
            o_swfi      <= 1'b0;
        end else if (i_we) begin
            case (i_offset)
                periph_pkg::TST_LED: o_led <= i_wdata[3:0];
                periph_pkg::TST_PHY: o_phy_rst_n <= i_wdata[0];
                periph_pkg::TST_SWI: begin
                    // Levels stay until software writes them back to 0
                    o_swi  <= i_wdata[0];
                    o_swfi <= i_wdata[1];
                end
                default: ;
            endcase
        end
    end

    // Read data and the read-only ID
    always_comb begin
        o_rdata = '0;
        case (i_offset)
            periph_pkg::TST_ID:  o_rdata = periph_pkg::TEST_ID;
            periph_pkg::TST_LED: o_rdata[3:0] = o_led;
            periph_pkg::TST_PHY: o_rdata[0] = o_phy_rst_n;
            periph_pkg::TST_SWI: o_rdata[1:0] = {o_swfi, o_swi};
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/periph_sys.sv ====
`timescale 1ns/1ns
`default_nettype none

module periph_sys #(
    parameter int N_TIMERS = 3
) (
    input  wire                          i_clk,
    input  wire                          i_arst_n,
    input  wire                          i_psel,
    input  wire                          i_penable,
    input  wire                          i_pwrite,
    input  wire  [bus_pkg::ADDR_W-1:0]   i_paddr,
    input  wire  [bus_pkg::DATA_W-1:0]   i_pwdata,
    input  wire  [1:0]                   i_ext_int,
    output logic [bus_pkg::DATA_W-1:0]   o_prdata,
    output logic                         o_pready,
    output logic                         o_pslverr,
    output logic                         o_irq,
    output logic                         o_firq,
    output logic [3:0]                   o_led,
    output logic                         o_phy_rst_n
);

    logic [bus_pkg::OFFS_W-1:0] offset;
    logic [bus_pkg::DATA_W-1:0] wdata;
    logic [bus_pkg::DATA_W-1:0] test_rdata;
    logic [bus_pkg::DATA_W-1:0] timer_rdata;
    logic [bus_pkg::DATA_W-1:0] irq_rdata;
    logic test_we;
    logic timer_we;
    logic irq_we;
    logic swi;
    logic swfi;
    logic [N_TIMERS-1:0] timer_int;

    // --------------------
    // Bus side
    apb_decoder u_apb_decoder (
        .i_clk          ( i_clk         ),
        .i_arst_n       ( i_arst_n      ),
        .i_psel         ( i_psel        ),
        .i_penable      ( i_penable     ),
        .i_pwrite       ( i_pwrite      ),
        .i_paddr        ( i_paddr       ),
        .i_pwdata       ( i_pwdata      ),
        .i_test_rdata   ( test_rdata    ),
        .i_timer_rdata  ( timer_rdata   ),
        .i_irq_rdata    ( irq_rdata     ),
        .o_prdata       ( o_prdata      ),
        .o_pready       ( o_pready      ),
        .o_pslverr      ( o_pslverr     ),
        .o_offset       ( offset        ),
        .o_wdata        ( wdata         ),
        .o_test_we      ( test_we       ),
        .o_timer_we     ( timer_we      ),
        .o_irq_we       ( irq_we        )
    );

    // --------------------
    // Timers and interrupt controller
    timer_bank #(
        .N_TIMERS       ( N_TIMERS      )
    ) u_timer_bank (
        .i_clk          ( i_clk         ),
        .i_arst_n       ( i_arst_n      ),
        .i_we           ( timer_we      ),
        .i_offset       ( offset        ),
        .i_wdata        ( wdata         ),
        .o_rdata        ( timer_rdata   ),
        .o_timer_int    ( timer_int     )
    );

    irq_controller #(
        .N_TIMERS       ( N_TIMERS      )
    ) u_irq_controller (
        .i_clk          ( i_clk         ),
        .i_arst_n       ( i_arst_n      ),
        .i_we           ( irq_we        ),
        .i_offset       ( offset        ),
        .i_wdata        ( wdata         ),
        .i_ext_int      ( i_ext_int     ),
        .i_swi          ( swi           ),
        .i_swfi         ( swfi          ),
        .i_timer_int    ( timer_int     ),
        .o_rdata        ( irq_rdata     ),
        .o_irq          ( o_irq         ),
        .o_firq         ( o_firq        )
    );

    // --------------------
    // LEDs, PHY reset and software interrupts
    test_regs u_test_regs (
        .i_clk          ( i_clk         ),
        .i_arst_n       ( i_arst_n      ),
        .i_we           ( test_we       ),
        .i_offset       ( offset        ),
        .i_wdata        ( wdata         ),
        .o_rdata        ( test_rdata    ),
        .o_led          ( o_led         ),
        .o_phy_rst_n    ( o_phy_rst_n   ),
        .o_swi          ( swi           ),
        .o_swfi         ( swfi          )
    );

endmodule

`default_nettype wire

// ==== testbench/tb_periph_sys.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_periph_sys;

    localparam logic [15:0] TEST_BASE = 16'h0000;
    localparam logic [15:0] IRQ_BASE  = 16'h2000;
    localparam logic [15:0] BAD_BASE  = 16'h5000;
    localparam logic [31:0] ID_VALUE  = 32'h0A23_0001;

    logic clk;
    logic arst_n;
    logic psel;
    logic penable;
    logic pwrite;
    logic [15:0] paddr;
    logic [31:0] pwdata;
    logic [1:0] ext_int;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic irq;
    logic firq;
    logic [3:0] led;
    logic phy_rst_n;

    int checks;
    int errors;
    int wait_cycles;
    logic [3:0] led_last;

    periph_sys #(
        .N_TIMERS       ( 3             )
    ) uut (
        .i_clk          ( clk           ),
        .i_arst_n       ( arst_n        ),
        .i_psel         ( psel          ),
        .i_penable      ( penable       ),
        .i_pwrite       ( pwrite        ),
        .i_paddr        ( paddr         ),
        .i_pwdata       ( pwdata        ),
        .i_ext_int      ( ext_int       ),
        .o_prdata       ( prdata        ),
        .o_pready       ( pready        ),
        .o_pslverr      ( pslverr       ),
        .o_irq          ( irq           ),
        .o_firq         ( firq          ),
        .o_led          ( led           ),
        .o_phy_rst_n    ( phy_rst_n     )
    );

    always #20 clk = ~clk;

    // --------------------
    // Helpers
    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    function automatic logic [15:0] timer_addr(input int idx, input logic [3:0] reg_offs);
        return 16'h1000 + 16'(idx * 16) + 16'(reg_offs);
    endfunction

    // Setup and access each start on a falling edge with outputs sampled mid-cycle
    task automatic apb_transfer(input logic wr, input logic [15:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int n;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #5;
        n = 0;
        while (pready !== 1'b1 && n < 4) begin
            @(negedge clk);
            #5;
            n++;
        end
        if (pready !== 1'b1) begin
            errors++;
            $display("Timeout: no o_pready for the transfer to address 0x%04h", addr);
        end
        wait_cycles = n;
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [15:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused_rdata;
        apb_transfer(1'b1, addr, data, unused_rdata, err);
    endtask

    task automatic apb_read(input logic [15:0] addr, output logic [31:0] data,
                            output logic err);
        apb_transfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic wait_irq_line(input logic use_firq, input logic level,
                                 input int max_cycles, input string what);
        int n;
        logic v;
        n = 0;
        v = use_firq ? firq : irq;
        while (v !== level && n < max_cycles) begin
            @(negedge clk);
            n++;
            v = use_firq ? firq : irq;
        end
        checks++;
        if (v !== level) begin
            errors++;
            $display("Timeout: %s did not reach %0b within %0d cycles", what, level, max_cycles);
        end
    endtask

    // --------------------
    // Directed tests
    task automatic reset_and_id();
        logic [31:0] data;
        logic err;
        compare_word("o_irq after reset", 32'(irq), 32'h0);
        compare_word("o_firq after reset", 32'(firq), 32'h0);
        compare_word("o_led after reset", 32'(led), 32'h0);
        compare_word("o_phy_rst_n after reset", 32'(phy_rst_n), 32'h0);
        apb_read(TEST_BASE + 16'(periph_pkg::TST_ID), data, err);
        compare_word("TST_ID", data, ID_VALUE);
        compare_word("TST_ID pslverr", 32'(err), 32'h0);
        checks++;
        if (wait_cycles != 0) begin
            errors++;
            $display("[ERROR] %0t ns: o_pready low in the first access cycle", $time);
        end
    endtask

    task automatic led_and_phy();
        logic [31:0] data;
        logic [3:0] v;
        logic err;
        int k;
        v = 4'h0;
        for (k = 0; k < 4; k++) begin
            v = 4'($urandom);
            apb_write(TEST_BASE + 16'(periph_pkg::TST_LED), {28'h0, v}, err);
            compare_word("o_led", 32'(led), 32'(v));
            apb_read(TEST_BASE + 16'(periph_pkg::TST_LED), data, err);
            compare_word("TST_LED readback", data, 32'(v));
        end
        led_last = v;
        apb_write(TEST_BASE + 16'(periph_pkg::TST_PHY), 32'h1, err);
        compare_word("o_phy_rst_n after release", 32'(phy_rst_n), 32'h1);
    endtask

    task automatic bus_errors();
        logic [31:0] data;
        logic err;
        // Offset matches TST_LED so a decode slip would show on the LEDs
        apb_write(BAD_BASE + 16'(periph_pkg::TST_LED), 32'hFFFF_FFFF, err);
        compare_word("pslverr on unmapped write", 32'(err), 32'h1);
        apb_read(BAD_BASE + 16'(periph_pkg::TST_LED), data, err);
        compare_word("pslverr on unmapped read", 32'(err), 32'h1);
        compare_word("unmapped read data", data, 32'h0);
        compare_word("o_led after unmapped write", 32'(led), 32'(led_last));
        compare_word("o_phy_rst_n after unmapped write", 32'(phy_rst_n), 32'h1);
        apb_read(TEST_BASE + 16'(periph_pkg::TST_LED), data, err);
        compare_word("TST_LED after unmapped write", data, 32'(led_last));
    endtask

    task automatic oneshot_timer();
        logic [31:0] data;
        logic [31:0] load;
        logic err;
        load = 32'(1 + ($urandom % 8));
        apb_write(IRQ_BASE + 16'(periph_pkg::IRQ_EN_SET), 32'h1 << 5, err);
        apb_write(timer_addr(1, periph_pkg::TMR_LOAD), load, err);
        // Enable, one-shot, DIV1
        apb_write(timer_addr(1, periph_pkg::TMR_CTRL), 32'h80, err);
        wait_irq_line(1'b0, 1'b1, int'(load) + 4, "o_irq from one-shot timer 1");
        apb_read(timer_addr(1, periph_pkg::TMR_VALUE), data, err);
        compare_word("timer 1 value after expiry", data, 32'h0);
        apb_write(timer_addr(1, periph_pkg::TMR_CLEAR), 32'h1, err);
        wait_irq_line(1'b0, 1'b0, 3, "o_irq after timer 1 clear");
        apb_write(timer_addr(1, periph_pkg::TMR_CTRL), 32'h0, err);
        apb_write(IRQ_BASE + 16'(periph_pkg::IRQ_EN_CLR), 32'h1 << 5, err);
    endtask

    task automatic periodic_masks();
        logic [31:0] data;
        logic [31:0] load;
        logic err;
        int k;
        load = 32'(16 + ($urandom % 16));
        apb_write(IRQ_BASE + 16'(periph_pkg::IRQ_EN_SET), 32'h1 << 4, err);
        apb_write(timer_addr(0, periph_pkg::TMR_LOAD), load, err);
        // Enable, periodic, DIV1
        apb_write(timer_addr(0, periph_pkg::TMR_CTRL), 32'hC0, err);
        wait_irq_line(1'b0, 1'b1, int'(load) + 4, "o_irq from periodic timer 0");
        apb_read(timer_addr(0, periph_pkg::TMR_VALUE), data, err);
        checks++;
        if (data == 32'h0 || data > load || data + 32'd4 < load) begin
            errors++;
            $display("[ERROR] %0t ns: timer 0 value 0x%08h, expected reload near 0x%08h",
                     $time, data, load);
        end
        apb_read(IRQ_BASE + 16'(periph_pkg::IRQ_RAW), data, err);
        compare_word("IRQ_RAW with timer 0 pending", data, 32'h10);
        apb_write(IRQ_BASE + 16'(periph_pkg::IRQ_EN_CLR), 32'h1 << 4, err);
        apb_read(IRQ_BASE + 16'(periph_pkg::IRQ_STATUS), data, err);
        compare_word("IRQ_STATUS with timer 0 masked", data, 32'h0);
        for (k = 0; k < 4; k++) begin
            compare_word("o_irq with timer 0 masked", 32'(irq), 32'h0);
            @(negedge clk);
        end
        apb_write(timer_addr(0, periph_pkg::TMR_CTRL), 32'h0, err);
        apb_write(timer_addr(0, periph_pkg::TMR_CLEAR), 32'h1, err);
    endtask

    task automatic soft_and_ext_irq();
        logic err;
        // Software irq source open in the irq mask so a swapped level shows on o_irq
        apb_write(IRQ_BASE + 16'(periph_pkg::IRQ_EN_SET), 32'h1 << 2, err);
        apb_write(IRQ_BASE + 16'(periph_pkg::FIRQ_EN_SET), 32'h1 << 3, err);
        apb_write(TEST_BASE + 16'(periph_pkg::TST_SWI), 32'h2, err);
        wait_irq_line(1'b1, 1'b1, 3, "o_firq from software firq");
        compare_word("o_irq with only firq source set", 32'(irq), 32'h0);
        apb_write(TEST_BASE + 16'(periph_pkg::TST_SWI), 32'h0, err);
        wait_irq_line(1'b1, 1'b0, 3, "o_firq after software firq cleared");
        apb_write(IRQ_BASE + 16'(periph_pkg::IRQ_EN_SET), 32'h1, err);
        @(negedge clk);
        ext_int = 2'b01;
        wait_irq_line(1'b0, 1'b1, 3, "o_irq from external interrupt 0");
        compare_word("o_firq with external interrupt 0", 32'(firq), 32'h0);
        @(negedge clk);
        ext_int = 2'b00;
        wait_irq_line(1'b0, 1'b0, 3, "o_irq after external interrupt 0 drops");
    endtask

    // --------------------
    initial begin
        void'($urandom(32'hd7f55523));
        clk         = 1'b0;
        arst_n      = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = 16'h0;
        pwdata      = 32'h0;
        ext_int     = 2'b00;
        checks      = 0;
        errors      = 0;
        wait_cycles = 0;
        led_last    = 4'h0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;

        reset_and_id();
        led_and_phy();
        bus_errors();
        oneshot_timer();
        periodic_masks();
        soft_and_ext_irq();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
src/bus_pkg.sv
src/periph_pkg.sv
src/apb_decoder.sv
src/timer_bank.sv
src/irq_controller.sv
src/test_regs.sv
src/periph_sys.sv
testbench/tb_periph_sys.sv

// ==== Makefile ====
# Verilator simulation of the APB peripheral subsystem

TOP := tb_periph_sys

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check for the pass line"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --timescale 1ns/1ns -j 0 --top-module $(TOP) -f sim.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
